// File: Makefile
# Verilator build and run of the beam combiner testbench
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= beam_combiner_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the simulation exits with a failing status on any $fatal or failed assertion
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/beam_combiner_properties.sv
`timescale 1ns/1ps

module beam_combiner_properties (
    input logic                 clock,
    input logic                 resetn,
    input logic                 s_tready,
    input logic                 m_tvalid,
    input logic                 m_tready,
    input beam_pkg::cplx_beat_t m_tdata,
    input logic                 m_tlast
);

    // all stages are empty right after reset, so nothing is offered yet
    after_reset_idle: assert property (@(posedge clock) $rose(resetn) |-> !m_tvalid)
        else $error("m_tvalid was high in the first cycle after reset");

    // a stalled output beat must not change until the sink takes it
    held_beat_stable: assert property (@(posedge clock) disable iff (!resetn)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
        else $error("output beat changed or vanished while m_tready was low");

    // once the output has drained for three cycles the input must be open
    ready_follows_output: assert property (@(posedge clock) disable iff (!resetn)
        m_tready && $past(m_tready) && $past(m_tready, 2) |-> s_tready)
        else $error("s_tready low although m_tready was high for three cycles");

endmodule

bind beam_combiner beam_combiner_properties u_properties (
    .clock    (clock),
    .resetn   (resetn),
    .s_tready (s_tready),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tlast  (m_tlast)
);

// File: dv/beam_combiner_tb.sv
`timescale 1ns/1ps

module beam_combiner_tb;

    import beam_pkg::*;

    // beats per test, also used to size the timeout
    localparam int ZERO_BEATS = 4;
    localparam int RANDOM_BEATS = 16;
    localparam int FRAME_BEATS = 8;
    localparam int SAT_BEATS = 8;
    localparam int LATENCY_BEATS = 12;
    localparam int STRESS_BEATS = 40;
    // two single beat frames only commit weights
    localparam int TOTAL_BEATS = ZERO_BEATS + RANDOM_BEATS + 2 * FRAME_BEATS + SAT_BEATS
                                 + LATENCY_BEATS + STRESS_BEATS + 2;
    localparam int CYCLE_LIMIT = 10 * TOTAL_BEATS + 200;
    localparam int RESET_CYCLES = 4;
    // a beat accepted on edge N leaves on edge N+3 while m_tready stays high
    localparam int OUT_LATENCY = 3;

    logic clock;
    logic resetn;
    logic weight_load;
    weight_t w00_re;
    weight_t w00_im;
    weight_t w01_re;
    weight_t w01_im;
    weight_t w20_re;
    weight_t w20_im;
    weight_t w21_re;
    weight_t w21_im;
    logic s_tvalid;
    logic s_tready;
    array_beat_t s_tdata;
    logic s_tlast;
    logic m_tvalid;
    logic m_tready;
    cplx_beat_t m_tdata;
    logic m_tlast;

    // weights on the ports, plus the model's own shadow and active sets
    weight_set_t port_weights;
    weight_set_t model_shadow;
    weight_set_t model_active;
    // expected beats in acceptance order, with their tlast and acceptance cycle
    cplx_beat_t exp_q[$];
    logic last_q[$];
    int accept_q[$];
    // set for beats whose latency is checked because m_tready stayed high
    bit timed_q[$];
    string test_name;
    bit hold_ready;
    int cycle_count;
    logic [15:0] lfsr_state;

    assign w00_re = port_weights[0].re;
    assign w00_im = port_weights[0].im;
    assign w01_re = port_weights[1].re;
    assign w01_im = port_weights[1].im;
    assign w20_re = port_weights[2].re;
    assign w20_im = port_weights[2].im;
    assign w21_re = port_weights[3].re;
    assign w21_im = port_weights[3].im;

    beam_combiner i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // 16 bit Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic weight_set_t random_weights();
        weight_set_t w;
        for (int c = 0; c < CHANNELS; c++) begin
            w[c].re = weight_t'(take_bits(WEIGHT_WIDTH));
            w[c].im = weight_t'(take_bits(WEIGHT_WIDTH));
        end
        return w;
    endfunction

    function automatic array_beat_t random_beat();
        array_beat_t beat;
        for (int c = 0; c < CHANNELS; c++) begin
            for (int l = 0; l < LANES; l++) begin
                beat[c].re[l] = sample_t'(take_bits(SAMPLE_WIDTH));
                beat[c].im[l] = sample_t'(take_bits(SAMPLE_WIDTH));
            end
        end
        return beat;
    endfunction

    // every channel carries the same extreme value in a lane so the sum cannot cancel
    function automatic array_beat_t extreme_beat();
        array_beat_t beat;
        sample_t pick_re;
        sample_t pick_im;
        for (int l = 0; l < LANES; l++) begin
            pick_re = take_bits(1) != 0 ? sample_t'(SAMPLE_MAX) : sample_t'(SAMPLE_MIN);
            pick_im = take_bits(1) != 0 ? sample_t'(SAMPLE_MAX) : sample_t'(SAMPLE_MIN);
            for (int c = 0; c < CHANNELS; c++) begin
                beat[c].re[l] = pick_re;
                beat[c].im[l] = pick_im;
            end
        end
        return beat;
    endfunction

    function automatic sample_t clamp_sample(input int value);
        if (value > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end
        if (value < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(value);
    endfunction

    // reference beam: floor of each complex product over 2**WEIGHT_FRAC, summed and clamped
    function automatic cplx_beat_t expected_beat(input array_beat_t data, input weight_set_t w);
        cplx_beat_t result;
        int acc_re;
        int acc_im;
        int prod_re;
        int prod_im;
        for (int l = 0; l < LANES; l++) begin
            acc_re = 0;
            acc_im = 0;
            for (int c = 0; c < CHANNELS; c++) begin
                prod_re = int'(data[c].re[l]) * int'(w[c].re)
                          - int'(data[c].im[l]) * int'(w[c].im);
                prod_im = int'(data[c].re[l]) * int'(w[c].im)
                          + int'(data[c].im[l]) * int'(w[c].re);
                acc_re += prod_re >>> WEIGHT_FRAC;
                acc_im += prod_im >>> WEIGHT_FRAC;
            end
            result.re[l] = clamp_sample(acc_re);
            result.im[l] = clamp_sample(acc_im);
        end
        return result;
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_beat(input string test, input cplx_beat_t expected,
                                input cplx_beat_t actual);
        if (expected !== actual) begin
            $display("ERR %s m_tdata expected %h actual %h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_last(input string test, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERR %s m_tlast expected %b actual %b", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_latency(input string test, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERR %s latency expected %0d actual %0d", test, expected, actual);
            abort_run();
        end
    endtask

    // model and checker, both work on the values present just before each rising edge
    always @(posedge clock) begin
        if (resetn) begin
            cycle_count++;
            if (cycle_count > CYCLE_LIMIT) begin
                $display("timeout after %0d cycles with %0d beats still expected",
                         cycle_count, exp_q.size());
                abort_run();
            end
            if (m_tvalid && m_tready) begin
                if (exp_q.size() == 0) begin
                    $display("%s: an output beat came out with no input beat outstanding",
                             test_name);
                    abort_run();
                end
                compare_beat(test_name, exp_q.pop_front(), m_tdata);
                compare_last(test_name, last_q.pop_front(), m_tlast);
                // with m_tready high the beat transfers on the first edge it is offered
                if (timed_q.pop_front()) begin
                    compare_latency(test_name, OUT_LATENCY, cycle_count - accept_q[0]);
                end
                void'(accept_q.pop_front());
            end
            // the beat uses the active set from before a commit on this same edge
            if (s_tvalid && s_tready) begin
                exp_q.push_back(expected_beat(s_tdata, model_active));
                last_q.push_back(s_tlast);
                accept_q.push_back(cycle_count);
                timed_q.push_back(hold_ready);
                if (s_tlast) begin
                    model_active = model_shadow;
                end
            end
            if (weight_load) begin
                model_shadow = port_weights;
            end
        end
    end

    // random back pressure only when the test does not hold m_tready high
    task automatic drive_ready();
        m_tready = hold_ready ? 1'b1 : 1'(take_bits(1));
    endtask

    task automatic idle_cycle(input bit load);
        weight_load = load;
        drive_ready();
        @(posedge clock);
        @(negedge clock);
        weight_load = 1'b0;
    endtask

    // offers one beat and keeps it steady until an edge with s_tready takes it
    task automatic send_beat(input array_beat_t data, input logic last, input bit load);
        logic accepted;
        s_tvalid = 1'b1;
        s_tdata = data;
        s_tlast = last;
        weight_load = load;
        do begin
            drive_ready();
            @(posedge clock);
            accepted = s_tready;
            @(negedge clock);
            weight_load = 1'b0;
        end while (!accepted);
        s_tvalid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            idle_cycle(1'b0);
        end
    endtask

    initial begin
        int gaps;
        bit load;
        lfsr_state = 16'd74;
        cycle_count = 0;
        model_shadow = '0;
        model_active = '0;
        port_weights = '0;
        resetn = 1'b0;
        weight_load = 1'b0;
        s_tvalid = 1'b0;
        s_tdata = '0;
        s_tlast = 1'b0;
        m_tready = 1'b1;
        hold_ready = 1'b1;
        test_name = "reset";
        repeat (RESET_CYCLES) @(negedge clock);
        resetn = 1'b1;

        // ports change but nothing is loaded, so every lane stays zero
        test_name = "zero_weights";
        port_weights = random_weights();
        for (int i = 0; i < ZERO_BEATS; i++) begin
            send_beat(random_beat(), i == ZERO_BEATS - 1, 1'b0);
        end
        drain();

        test_name = "random_weights";
        port_weights = random_weights();
        idle_cycle(1'b1);
        send_beat(random_beat(), 1'b1, 1'b0);
        for (int i = 0; i < RANDOM_BEATS; i++) begin
            send_beat(random_beat(), (i % 4) == 3, 1'b0);
        end
        drain();

        // a load after beat three must not reach the rest of that frame
        test_name = "mid_frame_load";
        for (int i = 0; i < 2 * FRAME_BEATS; i++) begin
            if (i == 3) begin
                port_weights = random_weights();
                idle_cycle(1'b1);
            end
            send_beat(random_beat(), (i % FRAME_BEATS) == FRAME_BEATS - 1, 1'b0);
        end
        drain();

        // a real weight of minus one on every channel makes four extreme samples
        // add up to four times the sample limit, so every lane clamps
        test_name = "saturation";
        port_weights = '0;
        for (int c = 0; c < CHANNELS; c++) begin
            port_weights[c].re = weight_t'(-128);
        end
        idle_cycle(1'b1);
        send_beat(random_beat(), 1'b1, 1'b0);
        for (int i = 0; i < SAT_BEATS; i++) begin
            send_beat(extreme_beat(), i == SAT_BEATS - 1, 1'b0);
        end
        drain();

        // back to back beats with the output always ready
        test_name = "latency";
        for (int i = 0; i < LATENCY_BEATS; i++) begin
            send_beat(random_beat(), (i % 5) == 4, 1'b0);
        end
        drain();

        // random gaps, tlast, weight loads and back pressure all at once
        test_name = "random_stall";
        hold_ready = 1'b0;
        for (int i = 0; i < STRESS_BEATS; i++) begin
            gaps = int'(take_bits(2));
            repeat (gaps) idle_cycle(1'b0);
            load = take_bits(3) == 0;
            if (load) begin
                port_weights = random_weights();
            end
            send_beat(random_beat(), take_bits(2) == 0 || i == STRESS_BEATS - 1, load);
        end
        hold_ready = 1'b1;
        drain();
        repeat (4) idle_cycle(1'b0);

        if (exp_q.size() != 0) begin
            $display("%0d expected beats never came out", exp_q.size());
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: flist.f
logic/beam_pkg.sv
logic/axis_if.sv
logic/weight_bank.sv
logic/complex_weighter.sv
logic/beam_summer.sv
logic/beam_combiner.sv
dv/beam_combiner_properties.sv
dv/beam_combiner_tb.sv

// File: logic/axis_if.sv
`timescale 1ns/1ps

// valid/ready stream with a single beat payload and a frame marker
interface axis_if #(
    parameter type payload_t = logic
);

    // a beat moves on a rising edge where tvalid and tready are both high
    logic     tvalid;
    logic     tready;
    payload_t tdata;
    // marks the final beat of a frame
    logic     tlast;

    // the source keeps tvalid, tdata and tlast steady until the beat is taken
    modport source (output tvalid, output tdata, output tlast, input tready);

    // the sink never looks at tvalid when it forms tready
    modport sink (input tvalid, input tdata, input tlast, output tready);

    // passive view for blocks that only watch the traffic
    modport monitor (input tvalid, input tready, input tdata, input tlast);

endinterface

// File: logic/beam_combiner.sv
`timescale 1ns/1ps

module beam_combiner (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  weight_load,
    input  beam_pkg::weight_t     w00_re,
    input  beam_pkg::weight_t     w00_im,
    input  beam_pkg::weight_t     w01_re,
    input  beam_pkg::weight_t     w01_im,
    input  beam_pkg::weight_t     w20_re,
    input  beam_pkg::weight_t     w20_im,
    input  beam_pkg::weight_t     w21_re,
    input  beam_pkg::weight_t     w21_im,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    input  beam_pkg::array_beat_t s_tdata,
    input  logic                  s_tlast,
    output logic                  m_tvalid,
    input  logic                  m_tready,
    output beam_pkg::cplx_beat_t  m_tdata,
    output logic                  m_tlast
);

    import beam_pkg::*;

    // weights in use for the current frame
    weight_set_t active_weights;

    // raw samples of all four channels
    axis_if #(.payload_t(array_beat_t)) in_bus ();
    // weighted channels on their way to the summer
    axis_if #(.payload_t(weighted_beat_t)) weighted_bus ();

    // the input ports act as the source of the input stream
    assign in_bus.tvalid = s_tvalid;
    assign in_bus.tdata = s_tdata;
    assign in_bus.tlast = s_tlast;
    assign s_tready = in_bus.tready;

    // the bank watches the input stream to find frame ends
    // channel 00 is index 0, 01 is 1, 20 is 2 and 21 is 3
    weight_bank u_weight_bank (
        .clock          (clock),
        .resetn         (resetn),
        .weight_load    (weight_load),
        .w00_re         (w00_re),
        .w00_im         (w00_im),
        .w01_re         (w01_re),
        .w01_im         (w01_im),
        .w20_re         (w20_re),
        .w20_im         (w20_im),
        .w21_re         (w21_re),
        .w21_im         (w21_im),
        .in_mon         (in_bus),
        .active_weights (active_weights)
    );

    // two register stages of complex multiply
    complex_weighter u_complex_weighter (
        .clock          (clock),
        .resetn         (resetn),
        .active_weights (active_weights),
        .in_bus         (in_bus),
        .out_bus        (weighted_bus)
    );

    // the third register stage drives the output ports
    beam_summer u_beam_summer (
        .clock    (clock),
        .resetn   (resetn),
        .in_bus   (weighted_bus),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast)
    );

endmodule

// File: logic/beam_pkg.sv
package beam_pkg;

    // stream geometry with four antenna channels and eight lanes in every beat
    localparam int CHANNELS = 4;
    localparam int LANES = 8;

    // samples are plain signed integers
    localparam int SAMPLE_WIDTH = 16;
    // weights are signed Q1.7, so 8'sd127 is just under one and 8'sh80 is minus one
    localparam int WEIGHT_WIDTH = 8;
    localparam int WEIGHT_FRAC = 7;

    // one extra bit holds the sum or difference of two full products
    localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH + 1;
    // dropping the fraction bits leaves the weighted value of one channel
    localparam int WEIGHTED_WIDTH = PRODUCT_WIDTH - WEIGHT_FRAC;
    // two guard bits are enough to add four channels without overflow
    localparam int SUM_WIDTH = WEIGHTED_WIDTH + 2;

    // output lanes clamp to the range of a sample
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_WIDTH - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_WIDTH - 1));

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

    // index 0 to 3 holds channels 00, 01, 20 and 21 in that order
    typedef cplx_weight_t [CHANNELS-1:0] weight_set_t;

    typedef sample_t [LANES-1:0] lane_vec_t;

    // one channel's complex beat
    typedef struct packed {
        lane_vec_t re;
        lane_vec_t im;
    } cplx_beat_t;

    // the input payload carries all channels under one handshake
    typedef cplx_beat_t [CHANNELS-1:0] array_beat_t;

    typedef logic signed [WEIGHTED_WIDTH-1:0] weighted_t;
    typedef weighted_t [LANES-1:0] weighted_vec_t;

    typedef struct packed {
        weighted_vec_t re;
        weighted_vec_t im;
    } cplx_weighted_t;

    // payload between the weighter and the summer
    typedef cplx_weighted_t [CHANNELS-1:0] weighted_beat_t;

endpackage

// File: logic/beam_summer.sv
`timescale 1ns/1ps

module beam_summer (
    input  logic                 clock,
    input  logic                 resetn,
    axis_if.sink                 in_bus,
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output beam_pkg::cplx_beat_t m_tdata,
    output logic                 m_tlast
);

    import beam_pkg::*;

    typedef logic signed [SUM_WIDTH-1:0] sum_t;

    // combined beat before the output register
    cplx_beat_t sum_beat;
    logic out_ready;

    // clamp a lane sum to the sample range instead of letting it wrap
    function automatic sample_t saturate(input sum_t value);
        if (value > sum_t'(SAMPLE_MAX)) begin
            return sample_t'(SAMPLE_MAX);
        end
        if (value < sum_t'(SAMPLE_MIN)) begin
            return sample_t'(SAMPLE_MIN);
        end
        return value[SAMPLE_WIDTH-1:0];
    endfunction

    // lane by lane sum over all channels, real and imaginary kept apart
    always_comb begin : lane_sums
        sum_t sum_re;
        sum_t sum_im;
        for (int l = 0; l < LANES; l++) begin
            sum_re = '0;
            sum_im = '0;
            // each weighted value is sign extended to the sum width first
            for (int c = 0; c < CHANNELS; c++) begin
                sum_re = sum_re + sum_t'(in_bus.tdata[c].re[l]);
                sum_im = sum_im + sum_t'(in_bus.tdata[c].im[l]);
            end
            sum_beat.re[l] = saturate(sum_re);
            sum_beat.im[l] = saturate(sum_im);
        end
    end

    // the output register holds its beat while the downstream sink stalls
    assign out_ready = !m_tvalid || m_tready;
    assign in_bus.tready = out_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            m_tvalid <= 1'b0;
            m_tlast <= 1'b0;
        end else if (out_ready) begin
            m_tvalid <= in_bus.tvalid;
            m_tlast <= in_bus.tlast;
        end
    end

    // data only moves with a real beat so it stays put between beats
    always_ff @(posedge clock) begin
        if (out_ready && in_bus.tvalid) begin
            m_tdata <= sum_beat;
        end
    end

endmodule

// File: logic/complex_weighter.sv
`timescale 1ns/1ps

module complex_weighter (
    input  logic                  clock,
    input  logic                  resetn,
    input  beam_pkg::weight_set_t active_weights,
    axis_if.sink                  in_bus,
    axis_if.source                out_bus
);

    import beam_pkg::*;

    // a single sample times weight product fits one bit short of the sum width
    typedef logic signed [PRODUCT_WIDTH-2:0] prod_t;
    typedef logic signed [PRODUCT_WIDTH-1:0] wide_t;

    // the four partial products of one complex multiply
    typedef struct packed {
        prod_t rr;
        prod_t ii;
        prod_t ri;
        prod_t ir;
    } prod_set_t;

    prod_set_t [CHANNELS-1:0][LANES-1:0] s1_prod;
    logic s1_valid;
    logic s1_last;
    logic s1_ready;

    weighted_beat_t s2_data;
    logic s2_valid;
    logic s2_last;
    logic s2_ready;

    // arithmetic shift floors toward minus infinity
    // the top bits that are dropped only repeat the sign for any Q1.7 weight
    function automatic weighted_t scale_down(input wide_t value);
        wide_t shifted;
        shifted = value >>> WEIGHT_FRAC;
        return shifted[WEIGHTED_WIDTH-1:0];
    endfunction

    // each stage takes a new beat when it is empty or when its own beat leaves
    assign s2_ready = !s2_valid || out_bus.tready;
    assign s1_ready = !s1_valid || s2_ready;
    assign in_bus.tready = s1_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s1_last <= 1'b0;
        end else if (s1_ready) begin
            s1_valid <= in_bus.tvalid;
            s1_last <= in_bus.tlast;
        end
    end

    // stage one multiplies with the weights active on the acceptance edge
    always_ff @(posedge clock) begin
        if (s1_ready && in_bus.tvalid) begin
            for (int c = 0; c < CHANNELS; c++) begin
                for (int l = 0; l < LANES; l++) begin
                    s1_prod[c][l].rr <= in_bus.tdata[c].re[l] * active_weights[c].re;
                    s1_prod[c][l].ii <= in_bus.tdata[c].im[l] * active_weights[c].im;
                    s1_prod[c][l].ri <= in_bus.tdata[c].re[l] * active_weights[c].im;
                    s1_prod[c][l].ir <= in_bus.tdata[c].im[l] * active_weights[c].re;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            s2_valid <= 1'b0;
            s2_last <= 1'b0;
        end else if (s2_ready) begin
            s2_valid <= s1_valid;
            s2_last <= s1_last;
        end
    end

    // stage two combines the partial products and drops the weight fraction
    // real part is re*wre - im*wim and imaginary part is re*wim + im*wre
    always_ff @(posedge clock) begin
        if (s2_ready && s1_valid) begin
            for (int c = 0; c < CHANNELS; c++) begin
                for (int l = 0; l < LANES; l++) begin
                    s2_data[c].re[l] <= scale_down(wide_t'(s1_prod[c][l].rr)
                                                   - wide_t'(s1_prod[c][l].ii));
                    s2_data[c].im[l] <= scale_down(wide_t'(s1_prod[c][l].ri)
                                                   + wide_t'(s1_prod[c][l].ir));
                end
            end
        end
    end

    assign out_bus.tvalid = s2_valid;
    assign out_bus.tdata = s2_data;
    assign out_bus.tlast = s2_last;

endmodule

// File: logic/weight_bank.sv
`timescale 1ns/1ps

module weight_bank (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  weight_load,
    input  beam_pkg::weight_t     w00_re,
    input  beam_pkg::weight_t     w00_im,
    input  beam_pkg::weight_t     w01_re,
    input  beam_pkg::weight_t     w01_im,
    input  beam_pkg::weight_t     w20_re,
    input  beam_pkg::weight_t     w20_im,
    input  beam_pkg::weight_t     w21_re,
    input  beam_pkg::weight_t     w21_im,
    axis_if.monitor               in_mon,
    output beam_pkg::weight_set_t active_weights
);

    import beam_pkg::*;

    // weights collected from the ports in channel index order
    weight_set_t port_weights;
    // loaded but not yet in use
    weight_set_t shadow_weights;
    logic frame_end;

    // channel names 00, 01, 20 and 21 map onto indices 0 to 3
    always_comb begin
        port_weights[0].re = w00_re;
        port_weights[0].im = w00_im;
        port_weights[1].re = w01_re;
        port_weights[1].im = w01_im;
        port_weights[2].re = w20_re;
        port_weights[2].im = w20_im;
        port_weights[3].re = w21_re;
        port_weights[3].im = w21_im;
    end

    // the last beat of a frame is being accepted on this edge
    assign frame_end = in_mon.tvalid && in_mon.tready && in_mon.tlast;

    // the active set only changes between frames so a frame never mixes two weight sets
    // a load on the commit edge lands in the shadow set and waits for the next frame end
    always_ff @(posedge clock) begin
        if (!resetn) begin
            shadow_weights <= '0;
            active_weights <= '0;
        end else begin
            if (weight_load) begin
                shadow_weights <= port_weights;
            end
            if (frame_end) begin
                active_weights <= shadow_weights;
            end
        end
    end

endmodule
